// ==== Makefile ====
SRC := src.f $(wildcard hdl/*.sv hdl/*.svh test/*.sv)

.PHONY: all run clean

all: run

obj_dir/VapbSysTb: $(SRC)
	verilator --binary --timing --assert -j 0 --top-module apbSysTb -f src.f

run: obj_dir/VapbSysTb
	obj_dir/VapbSysTb | tee sim.log
	grep -qx "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== hdl/ahbToApbBridge.sv ====
`timescale 1ns/10ps
`include "apbSys_params.svh"

module ahbToApbBridge (
    input  logic            HCLK,
    input  logic            HRESETn,
    input  apbSysPkg::addrT haddr_i,
    input  logic [1:0]      htrans_i,
    input  logic            hwrite_i,
    input  apbSysPkg::dataT hwdata_i,
    input  logic            hsel_i,
    input  logic            hready_i,
    input  apbSysPkg::dataT prdata_i,
    output apbSysPkg::dataT hrdata_o,
    output logic            hreadyout_o,
    output apbSysPkg::addrT paddr_o,
    output logic            pwrite_o,
    output apbSysPkg::dataT pwdata_o,
    output logic            penable_o,
    output logic            pselAny_o
);

    typedef enum logic [1:0] {
        stIdle,
        stSetup,
        stAccess
    } stateT;

    stateT state;
    logic  accept;

    // NONSEQ or SEQ while selected
    assign accept = hsel_i && hready_i && htrans_i[1];

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            state    <= stIdle;
            pwrite_o <= 1'b0;
        end else begin
            case (state)
                stIdle: begin
                    if (accept) begin
                        state    <= stSetup;
                        pwrite_o <= hwrite_i;
                    end
                end
                stSetup: state <= stAccess;
                default: state <= stIdle;
            endcase
        end
    end

    // Address and data path
    always_ff @(posedge HCLK) begin
        if (state == stIdle && accept) begin
            paddr_o <= haddr_i;
        end
        // AHB data phase lines up with the setup cycle
        if (state == stSetup) begin
            pwdata_o <= hwdata_i;
        end
        if (state == stAccess && !pwrite_o) begin
            hrdata_o <= prdata_i;
        end
    end

    // Stall the AHB side for setup and access
    assign hreadyout_o = (state == stIdle);
    assign pselAny_o   = (state != stIdle);
    assign penable_o   = (state == stAccess);

    // Every access cycle follows exactly one setup cycle
    assert property (@(posedge HCLK) disable iff (!HRESETn)
        penable_o |-> pselAny_o && $past(pselAny_o && !penable_o))
    else $error("penable without a preceding APB setup cycle");

endmodule

// ==== hdl/apbDecoder.sv ====
`timescale 1ns/10ps
`include "apbSys_params.svh"

module apbDecoder (
    input  apbSysPkg::addrT    paddr_i,
    input  logic               pselAny_i,
    input  apbSysPkg::dataT    prdataTimer0_i,
    input  apbSysPkg::dataT    prdataTimer1_i,
    input  apbSysPkg::dataT    prdataPwm_i,
    output apbSysPkg::slotSelT psel_o,
    output apbSysPkg::dataT    prdata_o
);

    apbSysPkg::slotT slot;

    assign slot = paddr_i[`SLOT_LSB +: `SLOT_W];

    // Slots 3 to 15 select nothing and read zero
    always_comb begin
        psel_o   = '0;
        prdata_o = '0;
        case (slot)
            apbSysPkg::slotT'(`SLOT_TIMER0): begin
                psel_o[`SLOT_TIMER0] = pselAny_i;
                prdata_o             = prdataTimer0_i;
            end
            apbSysPkg::slotT'(`SLOT_TIMER1): begin
                psel_o[`SLOT_TIMER1] = pselAny_i;
                prdata_o             = prdataTimer1_i;
            end
            apbSysPkg::slotT'(`SLOT_PWM): begin
                psel_o[`SLOT_PWM] = pselAny_i;
                prdata_o          = prdataPwm_i;
            end
            default: begin
                prdata_o = '0;
            end
        endcase
    end

    always_comb begin
        assert ($onehot0(psel_o) && (pselAny_i || psel_o == '0))
        else $error("psel not one-hot or active while bus idle: %b", psel_o);
    end

endmodule

// ==== hdl/apbSys.sv ====
`timescale 1ns/10ps
`include "apbSys_params.svh"

module apbSys (
    input  logic            HCLK,
    input  logic            HRESETn,
    input  apbSysPkg::addrT haddr_i,
    input  logic [1:0]      htrans_i,
    input  logic            hwrite_i,
    input  apbSysPkg::dataT hwdata_i,
    input  logic            hsel_i,
    input  logic            hready_i,
    output apbSysPkg::dataT hrdata_o,
    output logic            hreadyout_o,
    output logic [1:0]      irq_o,
    output logic            pwm_o
);

    // Shared APB bus
    apbSysPkg::addrT    paddr;
    apbSysPkg::dataT    pwdata;
    apbSysPkg::dataT    prdata;
    logic               pwrite;
    logic               penable;
    logic               pselAny;
    apbSysPkg::slotSelT psel;

    // Per slot read data
    apbSysPkg::dataT    prdataTimer0;
    apbSysPkg::dataT    prdataTimer1;
    apbSysPkg::dataT    prdataPwm;

    ahbToApbBridge bridge_i (
        .HCLK        (HCLK),
        .HRESETn     (HRESETn),
        .haddr_i     (haddr_i),
        .htrans_i    (htrans_i),
        .hwrite_i    (hwrite_i),
        .hwdata_i    (hwdata_i),
        .hsel_i      (hsel_i),
        .hready_i    (hready_i),
        .prdata_i    (prdata),
        .hrdata_o    (hrdata_o),
        .hreadyout_o (hreadyout_o),
        .paddr_o     (paddr),
        .pwrite_o    (pwrite),
        .pwdata_o    (pwdata),
        .penable_o   (penable),
        .pselAny_o   (pselAny)
    );

    apbDecoder decoder_i (
        .paddr_i        (paddr),
        .pselAny_i      (pselAny),
        .prdataTimer0_i (prdataTimer0),
        .prdataTimer1_i (prdataTimer1),
        .prdataPwm_i    (prdataPwm),
        .psel_o         (psel),
        .prdata_o       (prdata)
    );

    timerPeriph timer0_i (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .psel_i    (psel[`SLOT_TIMER0]),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .paddr_i   (paddr),
        .pwdata_i  (pwdata),
        .prdata_o  (prdataTimer0),
        .irq_o     (irq_o[0])
    );

    timerPeriph timer1_i (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .psel_i    (psel[`SLOT_TIMER1]),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .paddr_i   (paddr),
        .pwdata_i  (pwdata),
        .prdata_o  (prdataTimer1),
        .irq_o     (irq_o[1])
    );

    pwmPeriph pwm_i (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .psel_i    (psel[`SLOT_PWM]),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .paddr_i   (paddr),
        .pwdata_i  (pwdata),
        .prdata_o  (prdataPwm),
        .pwm_o     (pwm_o)
    );

endmodule

// ==== hdl/apbSysPkg.sv ====
`include "apbSys_params.svh"

package apbSysPkg;

    // Bus word and address
    typedef logic [`APB_DATA_W-1:0] dataT;
    typedef logic [`APB_ADDR_W-1:0] addrT;

    // Address fields
    typedef logic [`SLOT_W-1:0] slotT;
    typedef logic [`REG_W-1:0] regOffT;

    // One bit per populated slot
    typedef logic [`SLOT_COUNT-1:0] slotSelT;

endpackage

// ==== hdl/apbSys_params.svh ====
`ifndef APBSYS_PARAMS_SVH
`define APBSYS_PARAMS_SVH

// Bus widths
`define APB_DATA_W 32
`define APB_ADDR_W 32

// Slot field of the address, 1 MB per slot
`define SLOT_LSB 20
`define SLOT_W 4
`define SLOT_COUNT 3
`define SLOT_TIMER0 0
`define SLOT_TIMER1 1
`define SLOT_PWM 2

// Word offset inside a slot
`define REG_LSB 2
`define REG_W 3

// Timer registers
`define TMR_REG_COUNT 0
`define TMR_REG_PRE 1
`define TMR_REG_CMP 2
`define TMR_REG_CTRL 3
`define TMR_REG_STAT 4

// PWM registers, offset 0 reads the running count
`define PWM_REG_PRE 1
`define PWM_REG_PERIOD 2
`define PWM_REG_DUTY 3
`define PWM_REG_CTRL 4

`endif

// ==== hdl/pwmPeriph.sv ====
`timescale 1ns/10ps
`include "apbSys_params.svh"

module pwmPeriph (
    input  logic            HCLK,
    input  logic            HRESETn,
    input  logic            psel_i,
    input  logic            penable_i,
    input  logic            pwrite_i,
    input  apbSysPkg::addrT paddr_i,
    input  apbSysPkg::dataT pwdata_i,
    output apbSysPkg::dataT prdata_o,
    output logic            pwm_o
);

    apbSysPkg::dataT   count;
    apbSysPkg::dataT   preCnt;
    apbSysPkg::dataT   preVal;
    apbSysPkg::dataT   periodVal;
    apbSysPkg::dataT   dutyVal;
    apbSysPkg::regOffT regOff;
    logic              enable;
    logic              wrEn;
    logic              tick;

    assign regOff = paddr_i[`REG_LSB +: `REG_W];
    assign wrEn   = psel_i && penable_i && pwrite_i;
    assign tick   = enable && (preCnt >= preVal);

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            preVal    <= '0;
            periodVal <= '0;
            dutyVal   <= '0;
            enable    <= 1'b0;
        end else if (wrEn) begin
            case (regOff)
                apbSysPkg::regOffT'(`PWM_REG_PRE):    preVal    <= pwdata_i;
                apbSysPkg::regOffT'(`PWM_REG_PERIOD): periodVal <= pwdata_i;
                apbSysPkg::regOffT'(`PWM_REG_DUTY):   dutyVal   <= pwdata_i;
                apbSysPkg::regOffT'(`PWM_REG_CTRL):   enable    <= pwdata_i[0];
                default: ;
            endcase
        end
    end

    // Period is PERIOD+1 prescaled ticks
    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            preCnt <= '0;
            count  <= '0;
        end else begin
            if (enable) begin
                preCnt <= tick ? '0 : preCnt + 1;
            end
            if (tick) begin
                count <= (count >= periodVal) ? '0 : count + 1;
            end
        end
    end

    always_comb begin
        case (regOff)
            apbSysPkg::regOffT'(`PWM_REG_PRE):    prdata_o = preVal;
            apbSysPkg::regOffT'(`PWM_REG_PERIOD): prdata_o = periodVal;
            apbSysPkg::regOffT'(`PWM_REG_DUTY):   prdata_o = dutyVal;
            apbSysPkg::regOffT'(`PWM_REG_CTRL):   prdata_o = {{(`APB_DATA_W-1){1'b0}}, enable};
            default:                              prdata_o = count;
        endcase
    end

    // High for the first DUTY counts of each period
    assign pwm_o = enable && (count < dutyVal);

endmodule

// ==== hdl/timerPeriph.sv ====
`timescale 1ns/10ps
`include "apbSys_params.svh"

module timerPeriph (
    input  logic            HCLK,
    input  logic            HRESETn,
    input  logic            psel_i,
    input  logic            penable_i,
    input  logic            pwrite_i,
    input  apbSysPkg::addrT paddr_i,
    input  apbSysPkg::dataT pwdata_i,
    output apbSysPkg::dataT prdata_o,
    output logic            irq_o
);

    apbSysPkg::dataT   count;
    apbSysPkg::dataT   preCnt;
    apbSysPkg::dataT   preVal;
    apbSysPkg::dataT   cmpVal;
    apbSysPkg::regOffT regOff;
    logic              enable;
    logic              overflow;
    logic              wrEn;
    logic              tick;
    logic              wrap;

    assign regOff = paddr_i[`REG_LSB +: `REG_W];
    assign wrEn   = psel_i && penable_i && pwrite_i;
    assign tick   = enable && (preCnt >= preVal);
    // A CMP written below the count also wraps
    assign wrap   = tick && (count >= cmpVal);

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            preVal <= '0;
            cmpVal <= '0;
            enable <= 1'b0;
        end else if (wrEn) begin
            case (regOff)
                apbSysPkg::regOffT'(`TMR_REG_PRE):  preVal <= pwdata_i;
                apbSysPkg::regOffT'(`TMR_REG_CMP):  cmpVal <= pwdata_i;
                apbSysPkg::regOffT'(`TMR_REG_CTRL): enable <= pwdata_i[0];
                default: ;
            endcase
        end
    end

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            preCnt   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (enable) begin
                preCnt <= tick ? '0 : preCnt + 1;
            end
            if (wrap) begin
                count <= '0;
            end else if (tick) begin
                count <= count + 1;
            end
            // New overflow wins over a clear in the same cycle
            if (wrap) begin
                overflow <= 1'b1;
            end else if (wrEn && regOff == apbSysPkg::regOffT'(`TMR_REG_STAT) && pwdata_i[0]) begin
                overflow <= 1'b0;
            end
        end
    end

    always_comb begin
        case (regOff)
            apbSysPkg::regOffT'(`TMR_REG_COUNT): prdata_o = count;
            apbSysPkg::regOffT'(`TMR_REG_PRE):   prdata_o = preVal;
            apbSysPkg::regOffT'(`TMR_REG_CMP):   prdata_o = cmpVal;
            apbSysPkg::regOffT'(`TMR_REG_CTRL):  prdata_o = {{(`APB_DATA_W-1){1'b0}}, enable};
            apbSysPkg::regOffT'(`TMR_REG_STAT):  prdata_o = {{(`APB_DATA_W-1){1'b0}}, overflow};
            default:                             prdata_o = '0;
        endcase
    end

    assign irq_o = overflow;

    // Count stays within CMP while CMP is left unchanged
    assert property (@(posedge HCLK) disable iff (!HRESETn)
        enable && $past(enable) && $stable(cmpVal) && $past(count <= cmpVal)
        |-> count <= cmpVal)
    else $error("timer count %0d above compare %0d", count, cmpVal);

endmodule

// ==== src.f ====
+incdir+hdl
hdl/apbSysPkg.sv
hdl/ahbToApbBridge.sv
hdl/apbDecoder.sv
hdl/timerPeriph.sv
hdl/pwmPeriph.sv
hdl/apbSys.sv
test/apbSysTb.sv

// ==== test/apbSysTb.sv ====
`timescale 1ns/10ps
`include "apbSys_params.svh"

module apbSysTb;

    localparam int readyTimeout = 20;
    localparam int eventTimeout = 200;

    logic            HCLK;
    logic            HRESETn;
    apbSysPkg::addrT haddr;
    logic [1:0]      htrans;
    logic            hwrite;
    apbSysPkg::dataT hwdata;
    logic            hsel;
    logic            hready;
    apbSysPkg::dataT hrdata;
    logic            hreadyout;
    logic [1:0]      irq;
    logic            pwm;

    logic [31:0]     lfsr = 32'h9b98;
    int              checkCount = 0;
    int              errCount = 0;
    // Expected register contents by slot and word offset
    apbSysPkg::dataT model [32];

    apbSys dut_i (
        .HCLK        (HCLK),
        .HRESETn     (HRESETn),
        .haddr_i     (haddr),
        .htrans_i    (htrans),
        .hwrite_i    (hwrite),
        .hwdata_i    (hwdata),
        .hsel_i      (hsel),
        .hready_i    (hready),
        .hrdata_o    (hrdata),
        .hreadyout_o (hreadyout),
        .irq_o       (irq),
        .pwm_o       (pwm)
    );

    initial begin
        HCLK = 1'b0;
        forever #50 HCLK = ~HCLK;
    end

    // Right-shifting Galois LFSR with taps 32 31 29 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hD0000001) : (s >> 1);
    endfunction

    task automatic randBits(input int n, output apbSysPkg::dataT val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrStep(lfsr);
            val  = {val[`APB_DATA_W-2:0], lfsr[0]};
        end
    endtask

    function automatic logic [4:0] regIndex(input int slot, input int off);
        return {slot[1:0], off[2:0]};
    endfunction

    task automatic checkValue(input string what, input apbSysPkg::dataT got,
                              input apbSysPkg::dataT exp);
        checkCount++;
        assert (got === exp)
        else begin
            errCount++;
            $display("ERROR at %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Starts and ends on a falling edge with the bridge idle
    task automatic busTransfer(input logic isWrite, input int slot, input int off,
                               input apbSysPkg::dataT wdata, output apbSysPkg::dataT rdata);
        int lowCycles;
        lowCycles = 0;
        haddr  = (apbSysPkg::addrT'(slot) << `SLOT_LSB) | (apbSysPkg::addrT'(off) << `REG_LSB);
        htrans = 2'b10;
        hwrite = isWrite;
        hsel   = 1'b1;
        @(posedge HCLK);
        @(negedge HCLK);
        htrans = 2'b00;
        hsel   = 1'b0;
        hwdata = wdata;
        while (!hreadyout && lowCycles < readyTimeout) begin
            lowCycles++;
            @(negedge HCLK);
        end
        checkCount++;
        assert (hreadyout)
        else begin
            errCount++;
            $display("Timeout: hreadyout_o stayed low for %0d cycles at %0d ns",
                     lowCycles, $time);
        end
        checkValue("hreadyout_o low cycles", apbSysPkg::dataT'(lowCycles), 32'd2);
        rdata = hrdata;
    endtask

    task automatic ahbWrite(input int slot, input int off, input apbSysPkg::dataT data);
        apbSysPkg::dataT ignored;
        busTransfer(1'b1, slot, off, data, ignored);
    endtask

    task automatic readCheck(input int slot, input int off, input apbSysPkg::dataT exp);
        apbSysPkg::dataT got;
        busTransfer(1'b0, slot, off, '0, got);
        checkValue($sformatf("read of slot %0d offset %0d", slot, off), got, exp);
    endtask

    task automatic waitIrq(input logic which, output int cycles);
        cycles = 0;
        while (!irq[which] && cycles < eventTimeout) begin
            @(negedge HCLK);
            cycles++;
        end
        checkCount++;
        assert (irq[which])
        else begin
            errCount++;
            $display("Timeout: irq_o[%0d] never rose within %0d cycles", which, cycles);
        end
    endtask

    initial begin
        apbSysPkg::dataT r;
        int   slot;
        int   off;
        int   cycles;
        int   period;
        int   duty;
        int   highCount;
        logic prevPwm;
        haddr   = '0;
        htrans  = 2'b00;
        hwrite  = 1'b0;
        hwdata  = '0;
        hsel    = 1'b0;
        hready  = 1'b1;
        HRESETn = 1'b0;
        foreach (model[i]) model[i] = '0;
        repeat (10) @(posedge HCLK);
        @(negedge HCLK);
        HRESETn = 1'b1;

        checkValue("hreadyout_o after reset", apbSysPkg::dataT'(hreadyout), 1);
        checkValue("irq_o after reset", apbSysPkg::dataT'(irq), 0);
        checkValue("pwm_o after reset", apbSysPkg::dataT'(pwm), 0);
        for (int s = 0; s < `SLOT_COUNT; s++) begin
            for (int o = 0; o < 8; o++) begin
                readCheck(s, o, '0);
            end
        end

        // Timer offsets 1 to 2 and PWM offsets 1 to 3
        for (int i = 0; i < 40; i++) begin
            randBits(4, r);
            slot = int'(r % 3);
            randBits(4, r);
            off = (slot == `SLOT_PWM) ? 1 + int'(r % 3) : 1 + int'(r % 2);
            randBits(32, r);
            ahbWrite(slot, off, r);
            model[regIndex(slot, off)] = r;
            readCheck(slot, off, model[regIndex(slot, off)]);
            randBits(4, r);
            slot = int'(r % 3);
            randBits(3, r);
            off = int'(r);
            readCheck(slot, off, model[regIndex(slot, off)]);
        end

        for (int s = 3; s < 16; s++) begin
            randBits(3, r);
            off = int'(r);
            randBits(32, r);
            ahbWrite(s, off, r);
            readCheck(s, off, '0);
        end
        for (int s = 0; s < `SLOT_COUNT; s++) begin
            for (int o = 0; o < 8; o++) begin
                readCheck(s, o, model[regIndex(s, o)]);
            end
        end

        for (int t = 0; t < 2; t++) begin
            randBits(3, r);
            ahbWrite(t, `TMR_REG_PRE, '0);
            ahbWrite(t, `TMR_REG_CMP, r);
            model[regIndex(t, `TMR_REG_PRE)] = '0;
            model[regIndex(t, `TMR_REG_CMP)] = r;
            ahbWrite(t, `TMR_REG_CTRL, 1);
            waitIrq(t[0], cycles);
            // Count steps every cycle and wraps on the step after reaching CMP
            checkValue("cycles to timer overflow", apbSysPkg::dataT'(cycles), r + 1);
            checkValue("irq_o of the other timer", apbSysPkg::dataT'(irq[~t[0]]), 0);
            ahbWrite(t, `TMR_REG_CTRL, 0);
            readCheck(t, `TMR_REG_STAT, 1);
            ahbWrite(t, `TMR_REG_STAT, 1);
            checkValue("irq_o after status clear", apbSysPkg::dataT'(irq[t[0]]), 0);
            readCheck(t, `TMR_REG_STAT, 0);
        end

        for (int round = 0; round < 3; round++) begin
            randBits(4, r);
            period = int'(r % 15) + 1;
            randBits(4, r);
            duty = int'(r % period) + 1;
            ahbWrite(`SLOT_PWM, `PWM_REG_PRE, '0);
            ahbWrite(`SLOT_PWM, `PWM_REG_PERIOD, period);
            ahbWrite(`SLOT_PWM, `PWM_REG_DUTY, duty);
            model[regIndex(`SLOT_PWM, `PWM_REG_PRE)]    = '0;
            model[regIndex(`SLOT_PWM, `PWM_REG_PERIOD)] = period;
            model[regIndex(`SLOT_PWM, `PWM_REG_DUTY)]   = duty;
            readCheck(`SLOT_PWM, `PWM_REG_DUTY, duty);
            ahbWrite(`SLOT_PWM, `PWM_REG_CTRL, 1);
            prevPwm = pwm;
            cycles  = 0;
            while (!(!prevPwm && pwm) && cycles < eventTimeout) begin
                prevPwm = pwm;
                @(negedge HCLK);
                cycles++;
            end
            checkCount++;
            assert (!prevPwm && pwm)
            else begin
                errCount++;
                $display("Timeout: no rising edge on pwm_o within %0d cycles", cycles);
            end
            // Each period is PERIOD+1 cycles with the first DUTY of them high
            highCount = 0;
            for (int c = 0; c < 4 * (period + 1); c++) begin
                if (pwm) begin
                    highCount++;
                end
                @(negedge HCLK);
            end
            checkValue("pwm_o high cycles over 4 periods", highCount, 4 * duty);
            ahbWrite(`SLOT_PWM, `PWM_REG_CTRL, 0);
        end

        $display("Checks: %0d, errors: %0d", checkCount, errCount);
        if (errCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
